// File: design/upd1771c_params.svh
`ifndef UPD1771C_PARAMS_SVH
`define UPD1771C_PARAMS_SVH

////////////////////
// machine timing

// CLK cycles in one machine phase
`define UPD_PHASES 8

////////////////////
// tone bands of N

`define UPD_RANGE_08 8'h08  // lowest N that can make a tone
`define UPD_RANGE_10 8'h10
`define UPD_RANGE_20 8'h20
`define UPD_RANGE_40 8'h40  // reload pulse drives the tone from here up

////////////////////
// interrupt vectors

// offsets 0, 4, 8 and C are added per band
`define UPD_TONE_VEC_BASE 12'h020

`endif

// File: design/upd1771c_pkg.sv
package upd1771c_pkg;

  ////////////////////
  // sound path payloads

  // tone reload value N
  typedef logic [7:0] n_reload_t;

  // {invert, negative, magnitude[7:0]}
  typedef logic [9:0] da_word_t;

  // two's complement sample
  typedef logic [8:0] pcm_t;

  ////////////////////
  // interrupt support

  // program address
  typedef logic [11:0] int_vec_t;

  // band of N that selects the tone source
  typedef enum logic [2:0] {
    BELOW_08,  // no tone
    R08_0F,    // nuc bit 2
    R10_1F,    // nuc bit 1
    R20_3F,    // nuc bit 0
    R40_FF     // delayed reload pulse
  } tone_range_e;

endpackage

// File: design/clock_phase_gen.sv
`timescale 1ns/1ps
`include "upd1771c_params.svh"

module clock_phase_gen (
  input  logic CLK,
  input  logic rst_n,
  output logic cp1p,
  output logic cp2n,
  output logic clk4
);

  ////////////////////
  // phase positions

  // last state of the phase counter, cp1p fires here
  localparam logic [2:0] PH_LAST = 3'(`UPD_PHASES - 1);
  localparam logic [2:0] PH_CP2N = PH_LAST - 3'd3;  // three cycles ahead of cp1p
  localparam logic [2:0] PH_CLK4 = 3'd3;

  logic [2:0] ph_cnt;

  ////////////////////
  // phase counter

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ph_cnt <= 3'd0;
    end else if (ph_cnt == PH_LAST) begin
      ph_cnt <= 3'd0;  // wrap at end of phase
    end else begin
      ph_cnt <= ph_cnt + 3'd1;
    end
  end

  ////////////////////
  // strobe decode

  // each strobe is one CLK wide, once per phase
  always_comb begin
    cp1p = (ph_cnt == PH_LAST);
    cp2n = (ph_cnt == PH_CP2N);
    clk4 = (ph_cnt == PH_CLK4);
  end

endmodule

// File: design/phase_latch.sv
`timescale 1ns/1ps

module phase_latch
  import upd1771c_pkg::*;
#(
  parameter type payload_t = n_reload_t
) (
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     cp2n,
  input  logic     cp1p,
  input  logic     wr,
  input  payload_t d,
  output payload_t q
);

  payload_t stage_one;

  ////////////////////
  // two-phase transfer

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      stage_one <= '0;
      q         <= '0;
    end else begin
      if (cp2n) begin
        stage_one <= wr ? d : q;  // new value or hold current
      end
      if (cp1p) begin
        q <= stage_one;  // visible from the next phase on
      end
    end
  end

endmodule

// File: design/tone_counter.sv
`timescale 1ns/1ps
`include "upd1771c_params.svh"

module tone_counter
  import upd1771c_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      cp1p,
  input  n_reload_t n_reload,
  input  logic      tone_ie,
  output logic      tone_irq,
  output int_vec_t  tone_vec
);

  n_reload_t   nc;           // down counter
  logic        nc_eq_01;
  logic        reload_d;     // reload seen one phase ago
  logic [2:0]  nuc;          // reload counter
  tone_range_e n_range;
  logic        tone_cond;
  logic        tone_cond_d;
  logic        tone_fall;
  int_vec_t    vec_offset;

  assign nc_eq_01 = (nc == 8'd1);

  ////////////////////
  // NC and NUC

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      nc       <= '0;
      reload_d <= 1'b0;
      nuc      <= 3'd0;
    end else if (cp1p) begin
      if (nc_eq_01) begin
        nc <= n_reload;  // one reload every N phases
      end else begin
        nc <= nc - 8'd1;
      end
      reload_d <= nc_eq_01;
      if (reload_d) begin
        nuc <= nuc + 3'd1;
      end
    end
  end

  ////////////////////
  // band decode

  // 3F belongs to the 20-3F band
  always_comb begin
    if (n_reload < `UPD_RANGE_08) begin
      n_range = BELOW_08;
    end else if (n_reload < `UPD_RANGE_10) begin
      n_range = R08_0F;
    end else if (n_reload < `UPD_RANGE_20) begin
      n_range = R10_1F;
    end else if (n_reload < `UPD_RANGE_40) begin
      n_range = R20_3F;
    end else begin
      n_range = R40_FF;
    end
  end

  always_comb begin
    case (n_range)
      R08_0F:  tone_cond = nuc[2];
      R10_1F:  tone_cond = nuc[1];
      R20_3F:  tone_cond = nuc[0];
      R40_FF:  tone_cond = reload_d;
      default: tone_cond = 1'b0;  // N too small for a tone
    endcase
  end

  always_comb begin
    case (n_range)
      R10_1F:  vec_offset = 12'h004;
      R20_3F:  vec_offset = 12'h008;
      R40_FF:  vec_offset = 12'h00c;
      default: vec_offset = 12'h000;
    endcase
  end

  ////////////////////
  // trigger and vector

  assign tone_fall = tone_cond_d & ~tone_cond & tone_ie;  // falling edge only

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tone_cond_d <= 1'b0;
      tone_irq    <= 1'b0;
      tone_vec    <= '0;
    end else if (cp1p) begin
      tone_cond_d <= tone_cond;
      tone_irq    <= tone_fall;  // held for a full phase
      if (tone_fall) begin
        tone_vec <= `UPD_TONE_VEC_BASE + vec_offset;
      end
    end
  end

endmodule

// File: design/dac_output.sv
`timescale 1ns/1ps

module dac_output
  import upd1771c_pkg::*;
(
  input  da_word_t da,
  output pcm_t     pcm_out
);

  logic       da_invert;
  logic       da_negative;
  logic [7:0] da_mag;
  logic [7:0] sample_mag;

  ////////////////////
  // DA word fields

  assign da_invert   = da[9];
  assign da_negative = da[8];
  assign da_mag      = da[7:0];

  ////////////////////
  // sample inversion

  always_comb begin
    if (da_invert) begin
      sample_mag = ~da_mag;  // set when ss and ts differ
    end else begin
      sample_mag = da_mag;
    end
  end

  ////////////////////
  // 9-bit PCM

  // negative samples carry the complemented magnitude
  always_comb begin
    pcm_out[8] = da_negative;
    if (da_negative) begin
      pcm_out[7:0] = ~sample_mag;
    end else begin
      pcm_out[7:0] = sample_mag;
    end
  end

endmodule

// File: design/upd1771c_sound.sv
`timescale 1ns/1ps

module upd1771c_sound
  import upd1771c_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       n_wr,
  input  n_reload_t  n_data,
  input  logic       tone_ie,
  input  logic       da_wr,
  input  logic [7:0] da_data,
  input  logic       ss,
  input  logic       ts,
  output logic       tone_irq,
  output int_vec_t   tone_vec,
  output pcm_t       pcm_out
);

  logic      cp1p;
  logic      cp2n;
  n_reload_t n_reload;
  da_word_t  da_word;
  da_word_t  da_q;

  assign da_word = {ss ^ ts, ss, da_data};  // invert, sign, magnitude

  ////////////////////
  // phase clocks

  // clk4 has no load in the sound path
  clock_phase_gen u_phase (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cp1p  (cp1p),
    .cp2n  (cp2n),
    .clk4  ()
  );

  ////////////////////
  // host registers

  phase_latch #(.payload_t(n_reload_t)) u_n_latch (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cp2n  (cp2n),
    .cp1p  (cp1p),
    .wr    (n_wr),
    .d     (n_data),
    .q     (n_reload)
  );

  phase_latch #(.payload_t(da_word_t)) u_da_latch (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cp2n  (cp2n),
    .cp1p  (cp1p),
    .wr    (da_wr),
    .d     (da_word),
    .q     (da_q)
  );

  ////////////////////
  // tone and DAC

  tone_counter u_tone (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .cp1p     (cp1p),
    .n_reload (n_reload),
    .tone_ie  (tone_ie),
    .tone_irq (tone_irq),
    .tone_vec (tone_vec)
  );

  dac_output u_dac (
    .da      (da_q),
    .pcm_out (pcm_out)
  );

endmodule

// File: test/upd1771c_sound_assertions.sv
`timescale 1ns/1ps
`include "upd1771c_params.svh"

module upd1771c_sound_assertions
  import upd1771c_pkg::*;
(
  input logic      CLK,
  input logic      rst_n,
  input logic      tone_ie,
  input logic      tone_irq,
  input n_reload_t n_reload,
  input pcm_t      pcm_out
);

  ////////////////////
  // tone interrupt

  // irq is set on cp1p from the enable and N seen just before that edge
  irq_needs_enable: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(tone_irq) |-> $past(tone_ie))
    else $error("tone_irq raised while tone_ie was low");

  irq_needs_band: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(tone_irq) |-> ($past(n_reload) >= `UPD_RANGE_08))
    else $error("tone_irq raised with N below the lowest tone band");

  irq_one_phase: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(tone_irq) |-> tone_irq [*`UPD_PHASES] ##1 !tone_irq)
    else $error("tone_irq pulse is not one phase wide");

  ////////////////////
  // DAC

  pcm_reset: assert property (@(posedge CLK)
    !rst_n |=> (pcm_out == '0))
    else $error("pcm_out not cleared by reset");

endmodule

bind upd1771c_sound upd1771c_sound_assertions u_sound_assertions (
  .CLK      (CLK),
  .rst_n    (rst_n),
  .tone_ie  (tone_ie),
  .tone_irq (tone_irq),
  .n_reload (n_reload),
  .pcm_out  (pcm_out)
);

// File: test/tb_upd1771c_sound.sv
`timescale 1ns/1ps
`include "upd1771c_params.svh"

module tb_upd1771c_sound
  import upd1771c_pkg::*;
();

  localparam int MAX_RECORDS = 32;
  localparam int WR_SETTLE   = 2 * `UPD_PHASES;  // worst write latency

  logic       CLK;
  logic       rst_n;
  logic       n_wr;
  n_reload_t  n_data;
  logic       tone_ie;
  logic       da_wr;
  logic [7:0] da_data;
  logic       ss;
  logic       ts;
  logic       tone_irq;
  int_vec_t   tone_vec;
  pcm_t       pcm_out;

  logic [47:0] patterns [0:MAX_RECORDS-1];
  integer      seed;
  int          cycle_count;
  int          cycle_limit;

  upd1771c_sound u_upd1771c_sound (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .n_wr     (n_wr),
    .n_data   (n_data),
    .tone_ie  (tone_ie),
    .da_wr    (da_wr),
    .da_data  (da_data),
    .ss       (ss),
    .ts       (ts),
    .tone_irq (tone_irq),
    .tone_vec (tone_vec),
    .pcm_out  (pcm_out)
  );

  ////////////////////
  // clock and watchdog

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;  // 8 ns period

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("simulation timed out after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // helpers

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %t %s: got %0h, expected %0h", $realtime, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // 4x period per tone record plus 64 per record
  function automatic int cycle_budget();
    int total;
    int i;
    total = 0;
    for (i = 0; i < MAX_RECORDS; i++) begin
      if (patterns[i][47:44] != 4'h0) begin
        total += 64;
      end
      if (patterns[i][47:44] == 4'h1) begin
        total += 4 * int'(patterns[i][31:16]);
      end
    end
    return total;
  endfunction

  task automatic run_tone_record(input logic [47:0] rec);
    n_reload_t n;
    int        period;
    int_vec_t  vec;
    int        edges;
    int        t_now;
    int        t_prev;
    logic      irq_prev;
    n      = rec[43:36];
    period = int'(rec[31:16]);
    vec    = rec[11:0];
    @(posedge CLK);
    n_data  <= n;
    tone_ie <= rec[32];
    n_wr    <= 1'b1;
    repeat (`UPD_PHASES) @(posedge CLK);  // strobe spans one cp2n
    n_wr <= 1'b0;
    repeat (WR_SETTLE) @(posedge CLK);
    if (vec == '0) begin
      repeat (4 * period) begin  // quiet window
        @(negedge CLK);
        check_value($sformatf("tone_irq quiet, N %0h", n), tone_irq, 1'b0);
      end
    end else begin
      edges  = 0;
      t_now  = 0;
      t_prev = 0;
      @(negedge CLK);
      irq_prev = tone_irq;
      while (edges < 3) begin
        @(negedge CLK);
        t_now = t_now + 1;
        if (tone_irq && !irq_prev) begin
          edges = edges + 1;
          if (edges > 1) begin  // first edge may still follow the old N
            check_value($sformatf("tone_vec, N %0h", n), tone_vec, vec);
          end
          if (edges == 3) begin
            check_value($sformatf("tone_irq period, N %0h", n), t_now - t_prev, period);
          end
          t_prev = t_now;
        end
        irq_prev = tone_irq;
      end
    end
  endtask

  task automatic run_dac_record(input logic [47:0] rec);
    @(posedge CLK);
    da_data <= rec[43:36];
    ss      <= rec[32];
    ts      <= rec[28];
    da_wr   <= 1'b1;
    repeat (`UPD_PHASES) @(posedge CLK);  // strobe spans one cp2n
    da_wr <= 1'b0;
    repeat (WR_SETTLE) @(posedge CLK);
    @(negedge CLK);
    check_value($sformatf("pcm_out, data %0h ss %0b ts %0b", rec[43:36], rec[32], rec[28]),
                pcm_out, rec[8:0]);
  endtask

  ////////////////////
  // main sequence

  initial begin
    int         idx;
    int         gap;
    logic [3:0] kind;
    $timeformat(-9, 0, " ns", 0);
    seed        = 32'h2130501f;
    rst_n       = 1'b0;
    n_wr        = 1'b0;
    n_data      = '0;
    tone_ie     = 1'b0;
    da_wr       = 1'b0;
    da_data     = '0;
    ss          = 1'b0;
    ts          = 1'b0;
    cycle_count = 0;
    for (idx = 0; idx < MAX_RECORDS; idx++) begin
      patterns[idx] = '0;
    end
    $readmemh("test/tone_dac_patterns.hex", patterns);
    cycle_limit = cycle_budget();

    repeat (10) @(posedge CLK);
    rst_n <= 1'b1;
    @(negedge CLK);
    check_value("tone_irq after reset", tone_irq, 1'b0);
    check_value("tone_vec after reset", tone_vec, '0);
    check_value("pcm_out after reset", pcm_out, '0);

    idx = 0;
    while (idx < MAX_RECORDS && patterns[idx][47:44] != 4'h0) begin
      gap = $unsigned($random(seed)) % 8;  // idle cycles between writes
      repeat (gap) @(posedge CLK);
      kind = patterns[idx][47:44];
      if (kind == 4'h1) begin
        run_tone_record(patterns[idx]);
      end else if (kind == 4'h2) begin
        run_dac_record(patterns[idx]);
      end else begin
        $display("pattern record %0d has unknown kind %0h", idx, kind);
        $display("CHECKS FAILED");
        $fatal(1, "bad pattern record");
      end
      idx++;
    end

    if (idx > 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("no pattern records were read from the data file");
      $display("CHECKS FAILED");
      $fatal(1, "empty pattern file");
    end
  end

endmodule

// File: test/tone_dac_patterns.hex
// tone: 1_NN_ie_period_0_vec   period in CLK, vec 000 means no irq for 4x period cycles
// dac:  2_data_ss_ts_0000_pcm  pcm is the 9-bit sample, a kind of 0 ends the list
1_05_1_0400_0_000  // N below 08
2_3C_0_0_0000_03C
2_3C_0_1_0000_0C3
1_0C_1_0300_0_020  // 08-0F band, 64N
2_3C_1_0_0000_13C
1_18_1_0300_0_024  // 10-1F band, 32N
2_3C_1_1_0000_1C3
1_3F_1_03F0_0_028  // top of 20-3F band, 16N
1_40_1_0200_0_02C  // 40-FF band, 8N
2_A5_1_0_0000_1A5
1_A0_1_0500_0_02C
1_30_0_0400_0_000  // tone_ie low
2_00_1_1_0000_1FF
2_FF_0_1_0000_000
0_00_0_0000_0_000

// File: project.f
+incdir+design
design/upd1771c_pkg.sv
design/clock_phase_gen.sv
design/phase_latch.sv
design/tone_counter.sv
design/dac_output.sv
design/upd1771c_sound.sv
test/upd1771c_sound_assertions.sv
test/tb_upd1771c_sound.sv

// File: Bender.yml
package:
  name: upd1771c_sound

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/upd1771c_pkg.sv
      - design/clock_phase_gen.sv
      - design/phase_latch.sv
      - design/tone_counter.sv
      - design/dac_output.sv
      - design/upd1771c_sound.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/upd1771c_sound_assertions.sv
      - test/tb_upd1771c_sound.sv
